// File: dv/sdram_sched_assert.sv
/* Concurrent checks on ack, RD/WR spacing, DQ enable and ACT to RD/WR delay */
`timescale 1ns/10ps
`default_nettype none

module sdram_sched_assert (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        ack_o,
  input sdram_sched_pkg::sdram_cmd_e sdram_cmd_o,
  input sdram_sched_pkg::bank_t      sdram_ba_o,
  input logic                        sdram_dqoe_o
);
  import sdram_sched_pkg::*;

  logic is_rw;
  int   since_act [BANKS];

  assign is_rw = (sdram_cmd_o == CMD_RD) || (sdram_cmd_o == CMD_WR);

  // Cycles since the last ACT, per bank
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      for (int b = 0; b < BANKS; b++)
        since_act[b] <= 1000;
    end
    else
    begin
      for (int b = 0; b < BANKS; b++)
      begin
        if (sdram_cmd_o == CMD_ACT && sdram_ba_o == bank_t'(b))
          since_act[b] <= 1;
        else if (since_act[b] < 1000)
          since_act[b] <= since_act[b] + 1;
      end
    end
  end

  ack_with_rw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |-> is_rw) else $error("ack without RD or WR");

  rw_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    is_rw |=> !is_rw) else $error("RD or WR commands too close");

  dqoe_window: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sdram_dqoe_o |-> (sdram_cmd_o == CMD_WR) || $past(sdram_cmd_o == CMD_WR))
    else $error("DQ enable outside write window");

  rcd_min: assert property (@(posedge clk_i) disable iff (!rst_ni)
    is_rw |-> since_act[sdram_ba_o] >= T_RCD) else $error("tRCD violated");

endmodule

`default_nettype wire

// File: dv/sdram_sched_clkgen.sv
/* Testbench clock and reset generator */
`timescale 1ns/10ps
`default_nettype none

module sdram_sched_clkgen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD = 20;
  localparam int RST_CYCLES  = 4;

  initial
  begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #HALF_PERIOD clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: dv/sdram_sched_tb.sv
/* SDRAM scheduler testbench with stimulus, LFSR, memory model, reference
   read data, command order and timing checks and a watchdog */
`timescale 1ns/10ps
`default_nettype none

module sdram_sched_tb;
  import sdram_sched_pkg::*;

  localparam int N_TXN     = 120;
  localparam int BASE_CYC  = (N_TXN + 2) * 60 + 30;
  localparam int LIMIT_CYC = BASE_CYC + 50 * (BASE_CYC / T_REFI + 1);
  localparam int NEVER     = -1000;

  logic       clk;
  logic       rst_n;
  logic       req_i;
  logic       we_i;
  addr_t      addr_i;
  word_t      wdata_i;
  be_t        be_i;
  logic       ack_o;
  word_t      rdata_o;
  logic       rvalid_o;
  sdram_cmd_e sdram_cmd_o;
  bank_t      sdram_ba_o;
  sdram_a_t   sdram_a_o;
  dq_t        sdram_dq_i;
  dq_t        sdram_dq_o;
  logic       sdram_dqoe_o;
  dm_t        sdram_dm_o;

  logic [31:0] lfsr = 32'h4fe5;
  int          cyc;
  word_t       mem [addr_t];
  word_t       shadow [addr_t];
  word_t       exp_q [$];
  int          rd_cyc_q [$];
  dq_t         beat_q [16];
  logic        open_vld [BANKS];
  row_t        open_row [BANKS];
  int          last_act [BANKS];
  int          last_pre [BANKS];
  int          wr_end [BANKS];
  int          last_rc;
  int          ref_cnt;
  int          wr_cyc;
  addr_t       wr_addr;

  sdram_sched_clkgen clkgen_i (.clk_o(clk), .rst_no(rst_n));

  sdram_sched_top sdram_sched_top_i (
    .clk_i (clk), .rst_ni (rst_n), .req_i (req_i), .we_i (we_i),
    .addr_i (addr_i), .wdata_i (wdata_i), .be_i (be_i), .ack_o (ack_o),
    .rdata_o (rdata_o), .rvalid_o (rvalid_o), .sdram_cmd_o (sdram_cmd_o),
    .sdram_ba_o (sdram_ba_o), .sdram_a_o (sdram_a_o),
    .sdram_dq_i (sdram_dq_i), .sdram_dq_o (sdram_dq_o),
    .sdram_dqoe_o (sdram_dqoe_o), .sdram_dm_o (sdram_dm_o)
  );

  bind sdram_sched_top sdram_sched_assert sdram_sched_assert_i (.*);

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act)
      fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_cmd(input string name, input sdram_cmd_e exp,
                           input sdram_cmd_e act);
    if (exp !== act)
      fail_run($sformatf("ERROR %s: expected %s, actual %s", name, exp.name(),
                         act.name()));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
      fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
  endtask

  task automatic check_gap(input string name, input int gap, input int min);
    if (gap < min)
      fail_run($sformatf("%s only %0d cycles apart, minimum is %0d", name, gap, min));
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'ha300_0000 : 32'h0);
      v[i] = lfsr[0];
    end
    return v;
  endfunction

  // Initial memory content, unique per address
  function automatic word_t fill_word(input addr_t a);
    return {a[9:0], a} ^ 32'h5a00_0000;
  endfunction

  // Reference for a byte-enable write merge
  function automatic word_t merge_word(input word_t old, input word_t d, input be_t be);
    word_t w;
    w = old;
    for (int j = 0; j < BE_W; j++)
      if (be[j])
        w[j*8 +: 8] = d[j*8 +: 8];
    return w;
  endfunction

  function automatic word_t shadow_word(input addr_t a);
    return shadow.exists(a) ? shadow[a] : fill_word(a);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Cycle count and read beats from the memory model
  always @(posedge clk)
  begin
    cyc        <= cyc + 1;
    sdram_dq_i <= beat_q[(cyc + 1) % 16];
  end

  task automatic watch_cmd();
    bank_t      b;
    addr_t      a;
    sdram_cmd_e exp;
    word_t      w;
    int         beat;
    dm_t        mask;
    b = bank_t'(addr_i[ADDR_W-1 -: BA_W]);
    if (sdram_cmd_o == CMD_REF)
    begin
      for (int i = 0; i < BANKS; i++)
        check_bit("bank closed before REF", 1'b0, open_vld[i]);
      check_gap("ACT/REF to REF", cyc - last_rc, T_RC);
      last_rc = cyc;
      ref_cnt++;
    end
    else if (sdram_cmd_o == CMD_PRE && sdram_a_o[A10_BIT])
    begin
      for (int i = 0; i < BANKS; i++)
      begin
        if (open_vld[i])
        begin
          check_gap("ACT to PRE-all", cyc - last_act[i], T_RAS);
          check_gap("write end to PRE-all", cyc - wr_end[i], T_WR);
        end
        open_vld[i] = 1'b0;
        last_pre[i] = cyc;
      end
    end
    else if (sdram_cmd_o != CMD_NOP)
    begin
      if (!req_i)
        fail_run("SDRAM command issued while no request was pending");
      if (open_vld[b] && open_row[b] == addr_i[COL_W +: ROW_W])
        exp = we_i ? CMD_WR : CMD_RD;
      else if (!open_vld[b])
        exp = CMD_ACT;
      else
        exp = CMD_PRE;
      check_cmd("command order", exp, sdram_cmd_o);
      check_word("command bank", word_t'(b), word_t'(sdram_ba_o));
      case (sdram_cmd_o)
        CMD_ACT:
        begin
          check_word("ACT row", word_t'(addr_i[COL_W +: ROW_W]), word_t'(sdram_a_o));
          check_gap("PRE to ACT", cyc - last_pre[b], T_RP);
          check_gap("ACT/REF to ACT", cyc - last_rc, T_RC);
          open_vld[b] = 1'b1;
          open_row[b] = addr_i[COL_W +: ROW_W];
          last_act[b] = cyc;
          last_rc     = cyc;
        end
        CMD_PRE:
        begin
          check_gap("ACT to PRE", cyc - last_act[b], T_RAS);
          check_gap("write end to PRE", cyc - wr_end[b], T_WR);
          open_vld[b] = 1'b0;
          last_pre[b] = cyc;
        end
        default:
        begin
          check_word("column", word_t'(addr_i[COL_W-1:0]), word_t'(sdram_a_o));
          check_gap("ACT to RD/WR", cyc - last_act[b], T_RCD);
          a = {sdram_ba_o, open_row[b], sdram_a_o[COL_W-1:0]};
          if (sdram_cmd_o == CMD_WR)
          begin
            wr_cyc  = cyc;
            wr_addr = a;
            wr_end[b] = cyc + BURST_LEN - 1;
          end
          else
          begin
            w = mem.exists(a) ? mem[a] : fill_word(a);
            beat_q[(cyc + T_CL) % 16]     = w[15:0];
            beat_q[(cyc + T_CL + 1) % 16] = w[31:16];
            rd_cyc_q.push_back(cyc);
          end
        end
      endcase
    end
    check_bit("ack with RD/WR", sdram_cmd_o == CMD_RD || sdram_cmd_o == CMD_WR, ack_o);

    // Write beats are merged into the memory model under the mask
    if (cyc == wr_cyc || cyc == wr_cyc + 1)
    begin
      beat = cyc - wr_cyc;
      mask = ~be_i[beat*DM_W +: DM_W];
      check_bit("write DQ enable", 1'b1, sdram_dqoe_o);
      check_word("write beat", word_t'(wdata_i[beat*DQ_W +: DQ_W]), word_t'(sdram_dq_o));
      check_word("write mask", word_t'(mask), word_t'(sdram_dm_o));
      w = mem.exists(wr_addr) ? mem[wr_addr] : fill_word(wr_addr);
      for (int j = 0; j < DM_W; j++)
        if (!sdram_dm_o[j])
          w[beat*DQ_W + j*8 +: 8] = sdram_dq_o[j*8 +: 8];
      mem[wr_addr] = w;
    end
    else
      check_bit("DQ enable outside write", 1'b0, sdram_dqoe_o);
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
      watch_cmd();
  end

  // Read data compare
  always @(negedge clk)
  begin
    if (rst_n && rvalid_o)
    begin
      if (exp_q.size() == 0 || rd_cyc_q.size() == 0)
        fail_run("read data returned with no read outstanding");
      check_word("read data", exp_q.pop_front(), rdata_o);
      check_word("read latency", word_t'(T_CL + BURST_LEN),
                 word_t'(cyc - rd_cyc_q.pop_front()));
    end
  end

  task automatic run_txn(input logic we, input addr_t a, input word_t d, input be_t be);
    @(posedge clk);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= a;
    wdata_i <= d;
    be_i    <= be;
    if (we)
      shadow[a] = merge_word(shadow_word(a), d, be);
    else
      exp_q.push_back(shadow_word(a));
    do
      @(negedge clk);
    while (!ack_o);
    @(posedge clk);
    req_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] c;
    logic [31:0] we;
    logic [31:0] d;
    logic [31:0] be;
    req_i   <= 1'b0;
    we_i    <= 1'b0;
    addr_i  <= '0;
    wdata_i <= '0;
    be_i    <= '0;
    sdram_dq_i <= '0;
    cyc     = 0;
    last_rc = NEVER;
    ref_cnt = 0;
    wr_cyc  = NEVER;
    for (int i = 0; i < 16; i++)
      beat_q[i] = '0;
    for (int i = 0; i < BANKS; i++)
    begin
      open_vld[i] = 1'b0;
      last_act[i] = NEVER;
      last_pre[i] = NEVER;
      wr_end[i]   = NEVER;
    end
    wait (rst_n);
    repeat (20)
    begin
      @(negedge clk);
      check_cmd("reset command", CMD_NOP, sdram_cmd_o);
      check_bit("reset ack", 1'b0, ack_o);
      check_bit("reset rvalid", 1'b0, rvalid_o);
    end
    // Partial write, then read back
    run_txn(1'b1, addr_t'(22'h1_2345), 32'hdead_beef, 4'b0101);
    run_txn(1'b0, addr_t'(22'h1_2345), '0, '0);
    for (int t = 0; t < N_TXN; t++)
    begin
      b  = take_bits(2);
      r  = take_bits(2);
      c  = take_bits(3);
      we = take_bits(1);
      d  = take_bits(32);
      be = take_bits(4);
      run_txn(we[0], {bank_t'(b), row_t'(r) + row_t'(12'h010), col_t'(c)}, d, be);
    end
    while (exp_q.size() != 0)
      @(negedge clk);
    repeat (8) @(negedge clk);
    if (ref_cnt < cyc / T_REFI - REF_PEND_MAX)
      fail_run($sformatf("only %0d refreshes in %0d cycles", ref_cnt, cyc));
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

  // Watchdog
  initial
  begin
    repeat (LIMIT_CYC) @(posedge clk);
    fail_run("timeout, the run did not finish in time");
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the SDRAM scheduler testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module sdram_sched_tb -f sim.f -o sdram_sched_sim

./obj_dir/sdram_sched_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
  exit 0
else
  exit 1
fi

// File: sim.f
verilog/sdram_sched_pkg.sv
verilog/sdram_timer_if.sv
verilog/sdram_bank_timers.sv
verilog/sdram_refresh_timer.sv
verilog/sdram_cmd_fsm.sv
verilog/sdram_data_path.sv
verilog/sdram_sched_top.sv
dv/sdram_sched_clkgen.sv
dv/sdram_sched_assert.sv
dv/sdram_sched_tb.sv

// File: verilog/sdram_bank_timers.sv
/* Per-bank tRCD, tRAS, tRP and tWR down-counters plus the shared tRC
   counter, each with a done flag */
`timescale 1ns/10ps
`default_nettype none

module sdram_bank_timers (
  input  logic        clk_i,
  input  logic        rst_ni,
  sdram_timer_if.timers tmr
);
  import sdram_sched_pkg::*;

  // Slots 0..4*BANKS-1 hold the bank timers grouped by kind
  // (tRCD, tRAS, tRP, tWR); the last slot is tRC
  logic [BANKS-1:0] bank_sel;
  logic [4*BANKS:0] ld;
  logic [4*BANKS:0] done;
  logic [TMR_W-1:0] cnt [4*BANKS+1];

  // Counters start at T-1, so done rises in time for the decision
  // cycle whose command lands exactly T cycles later
  function automatic logic [TMR_W-1:0] load_value(input int slot);
    case (slot / BANKS)
      0:       load_value = TMR_W'(T_RCD - 1);
      1:       load_value = TMR_W'(T_RAS - 1);
      2:       load_value = TMR_W'(T_RP - 1);
      3:       load_value = TMR_W'(BURST_LEN + T_WR - 1);
      default: load_value = TMR_W'(T_RC - 1);
    endcase
  endfunction

  assign bank_sel = BANKS'(1) << tmr.bank_o;

  //////////////////////////////////////////////////////////////////////
  // Load strobes per slot
  assign ld[BANKS-1:0]         = {BANKS{tmr.act_o}} & bank_sel;
  assign ld[2*BANKS-1:BANKS]   = {BANKS{tmr.act_o}} & bank_sel;
  assign ld[3*BANKS-1:2*BANKS] = ({BANKS{tmr.pre_o}} & bank_sel) |
                                 {BANKS{tmr.pre_all_o}};
  // Write recovery covers both data beats
  assign ld[4*BANKS-1:3*BANKS] = {BANKS{tmr.rw_o && tmr.wr_o}} & bank_sel;
  assign ld[4*BANKS]           = tmr.act_o || tmr.ref_o;

  //////////////////////////////////////////////////////////////////////
  // Down-counters
  for (genvar i = 0; i <= 4*BANKS; i++)
  begin : g_cnt
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
      begin
        cnt[i]  <= '0;
        done[i] <= 1'b1;
      end
      else if (ld[i])
      begin
        cnt[i]  <= load_value(i);
        done[i] <= load_value(i) == '0;
      end
      else if (!done[i])
      begin
        cnt[i]  <= cnt[i] - 1'b1;
        done[i] <= cnt[i] == TMR_W'(1);
      end
    end
  end

  assign tmr.rcd_done = done[BANKS-1:0];
  assign tmr.ras_done = done[2*BANKS-1:BANKS];
  assign tmr.rp_done  = done[3*BANKS-1:2*BANKS];
  assign tmr.wr_done  = done[4*BANKS-1:3*BANKS];
  assign tmr.rc_done  = done[4*BANKS];

endmodule

`default_nettype wire

// File: verilog/sdram_cmd_fsm.sv
/* Open-row table, per-cycle command choice, registered SDRAM command
   outputs and request acknowledge */
`timescale 1ns/10ps
`default_nettype none

module sdram_cmd_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  sdram_sched_pkg::addr_t      addr_i,
  output logic                        ack_o,
  sdram_timer_if.fsm                  tmr,
  input  logic                        ref_pending_i,
  input  logic                        ref_urgent_i,
  output logic                        ref_issued_o,
  output logic                        rd_issue_o,
  output logic                        wr_issue_o,
  output sdram_sched_pkg::sdram_cmd_e sdram_cmd_o,
  output sdram_sched_pkg::bank_t      sdram_ba_o,
  output sdram_sched_pkg::sdram_a_t   sdram_a_o
);
  import sdram_sched_pkg::*;

  typedef enum logic {
    IDLE,
    REF_WAIT
  } sched_state_e;

  sched_state_e     state_q;
  sched_state_e     state_d;
  sdram_cmd_e       cmd_d;
  sdram_a_t         a_d;

  bank_t            req_bank;
  row_t             req_row;
  col_t             req_col;
  logic [BANKS-1:0] open_vld;
  row_t             open_row [BANKS];
  logic             req_live;
  logic             row_hit;
  logic             ref_go;

  assign req_bank = addr_i[ADDR_W-1 -: BA_W];
  assign req_row  = addr_i[COL_W +: ROW_W];
  assign req_col  = addr_i[COL_W-1:0];

  // The acked request is still on the inputs for one more cycle.
  // Masking it also keeps RD/WR commands BURST_LEN apart
  assign req_live = req_i && !ack_o;
  assign row_hit  = open_vld[req_bank] && (open_row[req_bank] == req_row);

  // Non-urgent refresh waits for the requester to go quiet
  assign ref_go = (state_q == REF_WAIT) || ref_urgent_i ||
                  (ref_pending_i && !req_live);

  //////////////////////////////////////////////////////////////////////
  // Command decision
  always_comb
  begin
    state_d       = state_q;
    cmd_d         = CMD_NOP;
    a_d           = '0;
    ref_issued_o  = 1'b0;
    rd_issue_o    = 1'b0;
    wr_issue_o    = 1'b0;
    tmr.act_o     = 1'b0;
    tmr.rw_o      = 1'b0;
    tmr.wr_o      = we_i;
    tmr.pre_o     = 1'b0;
    tmr.pre_all_o = 1'b0;
    tmr.ref_o     = 1'b0;
    tmr.bank_o    = req_bank;

    if (ref_go)
    begin
      // Close everything first, then refresh
      if (!(|open_vld))
      begin
        if (&tmr.rp_done && tmr.rc_done)
        begin
          cmd_d        = CMD_REF;
          tmr.ref_o    = 1'b1;
          ref_issued_o = 1'b1;
          state_d      = IDLE;
        end
      end
      else if (&tmr.ras_done && &tmr.wr_done)
      begin
        cmd_d          = CMD_PRE;
        a_d[A10_BIT]   = 1'b1;
        tmr.pre_all_o  = 1'b1;
        state_d        = REF_WAIT;
      end
    end
    else if (req_live)
    begin
      if (row_hit)
      begin
        if (tmr.rcd_done[req_bank])
        begin
          cmd_d      = we_i ? CMD_WR : CMD_RD;
          a_d        = sdram_a_t'(req_col);
          tmr.rw_o   = 1'b1;
          rd_issue_o = !we_i;
          wr_issue_o = we_i;
        end
      end
      else if (!open_vld[req_bank])
      begin
        if (tmr.rp_done[req_bank] && tmr.rc_done)
        begin
          cmd_d     = CMD_ACT;
          a_d       = sdram_a_t'(req_row);
          tmr.act_o = 1'b1;
        end
      end
      // Row miss
      else if (tmr.ras_done[req_bank] && tmr.wr_done[req_bank])
      begin
        cmd_d     = CMD_PRE;
        tmr.pre_o = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q     <= IDLE;
      sdram_cmd_o <= CMD_NOP;
      ack_o       <= 1'b0;
      open_vld    <= '0;
    end
    else
    begin
      state_q     <= state_d;
      sdram_cmd_o <= cmd_d;
      ack_o       <= rd_issue_o || wr_issue_o;
      if (tmr.pre_all_o)
        open_vld <= '0;
      else if (tmr.pre_o)
        open_vld[req_bank] <= 1'b0;
      else if (tmr.act_o)
        open_vld[req_bank] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    sdram_ba_o <= req_bank;
    sdram_a_o  <= a_d;
    if (tmr.act_o)
      open_row[req_bank] <= req_row;
  end

endmodule

`default_nettype wire

// File: verilog/sdram_data_path.sv
/* Write beat shifter with DQ enable and mask, read beat capture and
   word assembly with valid timing */
`timescale 1ns/10ps
`default_nettype none

module sdram_data_path (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rd_issue_i,
  input  logic                   wr_issue_i,
  input  sdram_sched_pkg::word_t wdata_i,
  input  sdram_sched_pkg::be_t   be_i,
  input  sdram_sched_pkg::dq_t   sdram_dq_i,
  output sdram_sched_pkg::dq_t   sdram_dq_o,
  output logic                   sdram_dqoe_o,
  output sdram_sched_pkg::dm_t   sdram_dm_o,
  output sdram_sched_pkg::word_t rdata_o,
  output logic                   rvalid_o
);
  import sdram_sched_pkg::*;

  word_t                     wr_buf;
  be_t                       dm_buf;
  logic [BURST_LEN-1:0]      oe_sr;
  logic [T_CL+BURST_LEN-1:0] rd_pipe;
  word_t                     rd_buf;

  //////////////////////////////////////////////////////////////////////
  // Write side shifts out the low half first
  always_ff @(posedge clk_i)
  begin
    if (wr_issue_i)
    begin
      wr_buf <= wdata_i;
      dm_buf <= ~be_i;
    end
    else
    begin
      wr_buf <= wr_buf >> DQ_W;
      dm_buf <= dm_buf >> DM_W;
    end
  end

  // One enable bit per beat
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      oe_sr <= '0;
    else if (wr_issue_i)
      oe_sr <= '1;
    else
      oe_sr <= oe_sr >> 1;
  end

  assign sdram_dq_o   = wr_buf[DQ_W-1:0];
  assign sdram_dm_o   = dm_buf[DM_W-1:0];
  assign sdram_dqoe_o = oe_sr[0];

  //////////////////////////////////////////////////////////////////////
  // Bit k of rd_pipe is set k cycles after the RD command
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rd_pipe  <= '0;
      rvalid_o <= 1'b0;
    end
    else
    begin
      rd_pipe  <= {rd_pipe[T_CL+BURST_LEN-2:0], rd_issue_i};
      rvalid_o <= rd_pipe[T_CL+BURST_LEN-1];
    end
  end

  // Beats enter at the top so the first ends up in the low half
  always_ff @(posedge clk_i)
  begin
    if (|rd_pipe[T_CL +: BURST_LEN])
      rd_buf <= {sdram_dq_i, rd_buf[WORD_W-1:DQ_W]};
  end

  assign rdata_o = rd_buf;

endmodule

`default_nettype wire

// File: verilog/sdram_refresh_timer.sv
/* Refresh interval counter and saturating count of owed refreshes */
`timescale 1ns/10ps
`default_nettype none

module sdram_refresh_timer (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ref_issued_i,
  output logic ref_pending_o,
  output logic ref_urgent_o
);
  import sdram_sched_pkg::*;

  typedef logic [$clog2(T_REFI)-1:0]         refi_t;
  typedef logic [$clog2(REF_PEND_MAX+1)-1:0] pend_t;

  refi_t refi_cnt;
  pend_t pend_cnt;
  logic  refi_expired;

  assign refi_expired = refi_cnt == '0;

  // One expiry every T_REFI cycles
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      refi_cnt <= refi_t'(T_REFI - 1);
    else if (refi_expired)
      refi_cnt <= refi_t'(T_REFI - 1);
    else
      refi_cnt <= refi_cnt - 1'b1;
  end

  // Expiry together with an issued REF leaves the count alone
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      pend_cnt <= '0;
    else if (refi_expired && !ref_issued_i && !ref_urgent_o)
      pend_cnt <= pend_cnt + 1'b1;
    else if (!refi_expired && ref_issued_i && ref_pending_o)
      pend_cnt <= pend_cnt - 1'b1;
  end

  assign ref_pending_o = pend_cnt != '0;
  assign ref_urgent_o  = pend_cnt == pend_t'(REF_PEND_MAX);

endmodule

`default_nettype wire

// File: verilog/sdram_sched_pkg.sv
/* Sizes, timing minima, vector types and the SDRAM command encoding
   shared by the single-port command scheduler */
`default_nettype none

package sdram_sched_pkg;

  //////////////////////////////////////////////////////////////////////
  // Address and data sizes
  localparam int BA_W      = 2;
  localparam int BANKS     = 1 << BA_W;
  localparam int ROW_W     = 12;
  localparam int COL_W     = 8;
  localparam int ADDR_W    = BA_W + ROW_W + COL_W;
  localparam int A_W       = 12;
  // A10 high on PRE closes every bank
  localparam int A10_BIT   = 10;
  localparam int WORD_W    = 32;
  localparam int BE_W      = WORD_W / 8;
  localparam int DQ_W      = 16;
  localparam int DM_W      = DQ_W / 8;
  localparam int BURST_LEN = WORD_W / DQ_W;

  //////////////////////////////////////////////////////////////////////
  // Timing minima in clock cycles
  localparam int T_RCD        = 3;
  localparam int T_RP         = 3;
  localparam int T_RAS        = 6;
  localparam int T_RC         = 9;
  // Counted from the last write beat
  localparam int T_WR         = 2;
  localparam int T_CL         = 3;
  // Short refresh interval for simulation
  localparam int T_REFI       = 200;
  localparam int REF_PEND_MAX = 4;
  localparam int TMR_W        = 4;

  typedef logic [BA_W-1:0]   bank_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [COL_W-1:0]  col_t;
  // Bank in the top bits, column in the bottom
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [BE_W-1:0]   be_t;
  typedef logic [DQ_W-1:0]   dq_t;
  typedef logic [DM_W-1:0]   dm_t;
  typedef logic [A_W-1:0]    sdram_a_t;

  typedef enum logic [2:0] {
    CMD_NOP,
    CMD_ACT,
    CMD_RD,
    CMD_WR,
    CMD_PRE,
    CMD_REF
  } sdram_cmd_e;

endpackage

`default_nettype wire

// File: verilog/sdram_sched_top.sv
/* Single-port SDRAM command scheduler top level */
`timescale 1ns/10ps
`default_nettype none

module sdram_sched_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        req_i,
  input  logic                        we_i,
  input  sdram_sched_pkg::addr_t      addr_i,
  input  sdram_sched_pkg::word_t      wdata_i,
  input  sdram_sched_pkg::be_t        be_i,
  output logic                        ack_o,
  output sdram_sched_pkg::word_t      rdata_o,
  output logic                        rvalid_o,
  output sdram_sched_pkg::sdram_cmd_e sdram_cmd_o,
  output sdram_sched_pkg::bank_t      sdram_ba_o,
  output sdram_sched_pkg::sdram_a_t   sdram_a_o,
  input  sdram_sched_pkg::dq_t        sdram_dq_i,
  output sdram_sched_pkg::dq_t        sdram_dq_o,
  output logic                        sdram_dqoe_o,
  output sdram_sched_pkg::dm_t        sdram_dm_o
);

  logic ref_pending;
  logic ref_urgent;
  logic ref_issued;
  logic rd_issue;
  logic wr_issue;

  sdram_timer_if tmr_if ();

  sdram_bank_timers bank_timers_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tmr    (tmr_if.timers)
  );

  sdram_refresh_timer refresh_timer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ref_issued_i  (ref_issued),
    .ref_pending_o (ref_pending),
    .ref_urgent_o  (ref_urgent)
  );

  sdram_cmd_fsm cmd_fsm_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .ack_o         (ack_o),
    .tmr           (tmr_if.fsm),
    .ref_pending_i (ref_pending),
    .ref_urgent_i  (ref_urgent),
    .ref_issued_o  (ref_issued),
    .rd_issue_o    (rd_issue),
    .wr_issue_o    (wr_issue),
    .sdram_cmd_o   (sdram_cmd_o),
    .sdram_ba_o    (sdram_ba_o),
    .sdram_a_o     (sdram_a_o)
  );

  // Write data and byte enables are still held by the requester
  sdram_data_path data_path_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_issue_i   (rd_issue),
    .wr_issue_i   (wr_issue),
    .wdata_i      (wdata_i),
    .be_i         (be_i),
    .sdram_dq_i   (sdram_dq_i),
    .sdram_dq_o   (sdram_dq_o),
    .sdram_dqoe_o (sdram_dqoe_o),
    .sdram_dm_o   (sdram_dm_o),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o)
  );

endmodule

`default_nettype wire

// File: verilog/sdram_timer_if.sv
/* Timer load strobes from the command FSM, done flags back from the timers */
`timescale 1ns/10ps
`default_nettype none

interface sdram_timer_if;
  import sdram_sched_pkg::*;

  // One-cycle strobes, issued with the command decision
  logic             act_o;
  logic             rw_o;
  logic             wr_o;
  logic             pre_o;
  logic             pre_all_o;
  logic             ref_o;
  bank_t            bank_o;

  // High once the minimum has elapsed
  logic [BANKS-1:0] rcd_done;
  logic [BANKS-1:0] ras_done;
  logic [BANKS-1:0] rp_done;
  logic [BANKS-1:0] wr_done;
  logic             rc_done;

  modport fsm (
    output act_o, rw_o, wr_o, pre_o, pre_all_o, ref_o, bank_o,
    input  rcd_done, ras_done, rp_done, wr_done, rc_done
  );

  modport timers (
    input  act_o, rw_o, wr_o, pre_o, pre_all_o, ref_o, bank_o,
    output rcd_done, ras_done, rp_done, wr_done, rc_done
  );

endinterface

`default_nettype wire
